// File: hdl/feat_core.sv
`timescale 1ns/100ps

module feat_core (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  feat_pkg::pixel_t            threshold,
    input  feat_pkg::row_wr_t           img_wr,
    input  logic [feat_pkg::row_aw-1:0] blur_rd_addr,
    output feat_pkg::row_t              blur_dout,
    input  logic [feat_pkg::kpt_aw-1:0] kpt_rd_addr,
    output feat_pkg::kpt_t              kpt_dout,
    output logic [feat_pkg::kpt_cw-1:0] kpt_count,
    output logic                        busy,
    output logic                        done
);

    feat_pkg::row_wr_t           img_port;
    feat_pkg::row_wr_t           blur_port;
    feat_pkg::row_wr_t           blur_wr;
    logic [feat_pkg::row_aw-1:0] img_rd_addr;
    logic [feat_pkg::row_aw-1:0] blur_mem_addr;
    logic [feat_pkg::row_aw-1:0] blur_img_addr;
    logic [feat_pkg::row_aw-1:0] detect_addr;
    feat_pkg::row_t              img_dout;
    feat_pkg::row_t              upper;
    feat_pkg::row_t              center;
    feat_pkg::row_t              lower;
    logic                        shift;
    logic                        fill_zero;
    logic                        blur_start;
    logic                        blur_done;
    logic                        detect_start;
    logic                        detect_done;

    feat_seq feat_seq_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .blur_done      (blur_done),
        .detect_done    (detect_done),
        .host_img_wr    (img_wr),
        .host_blur_addr (blur_rd_addr),
        .blur_img_addr  (blur_img_addr),
        .blur_wr        (blur_wr),
        .detect_addr    (detect_addr),
        .img_port       (img_port),
        .img_rd_addr    (img_rd_addr),
        .blur_port      (blur_port),
        .blur_rd_addr   (blur_mem_addr),
        .blur_start     (blur_start),
        .detect_start   (detect_start),
        .busy           (busy),
        .done           (done)
    );

    row_mem img_mem_inst (
        .clk     (clk),
        .wr      (img_port),
        .rd_addr (img_rd_addr),
        .dout    (img_dout)
    );

    row_mem blur_mem_inst (
        .clk     (clk),
        .wr      (blur_port),
        .rd_addr (blur_mem_addr),
        .dout    (blur_dout)   // shared by host and detect phase
    );

    line_buffer line_buffer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift),
        .fill_zero (fill_zero),
        .din       (img_dout),
        .upper     (upper),
        .center    (center),
        .lower     (lower)
    );

    gauss_blur gauss_blur_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (blur_start),
        .img_addr  (blur_img_addr),
        .img_dout  (img_dout),
        .upper     (upper),
        .center    (center),
        .lower     (lower),
        .shift     (shift),
        .fill_zero (fill_zero),
        .blur_wr   (blur_wr),
        .done      (blur_done)
    );

    kpt_detect kpt_detect_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (detect_start),
        .threshold   (threshold),
        .rd_addr     (detect_addr),
        .img_dout    (img_dout),
        .blur_dout   (blur_dout),
        .kpt_rd_addr (kpt_rd_addr),
        .kpt_dout    (kpt_dout),
        .kpt_count   (kpt_count),
        .done        (detect_done)
    );

endmodule

// File: hdl/feat_pkg.sv
package feat_pkg;

    localparam int n_rows = 16;
    localparam int n_cols = 16;
    localparam int pix_w  = 8;
    localparam int row_aw = 4;
    localparam int kpt_aw = 8;   // up to 256 keypoints
    localparam int kpt_cw = 9;

    typedef logic [pix_w-1:0] pixel_t;

    // pixel 0 sits in the low bits
    typedef logic [n_cols*pix_w-1:0] row_t;

    typedef struct packed {
        logic [row_aw-1:0] row;
        logic [row_aw-1:0] col;   // image is square
    } kpt_t;

    typedef struct packed {
        logic              we;
        logic [row_aw-1:0] addr;
        row_t              data;
    } row_wr_t;

    typedef enum logic [1:0] {
        idle   = 2'd0,
        blur   = 2'd1,
        detect = 2'd2
    } seq_state_t;

endpackage

// File: hdl/feat_seq.sv
`timescale 1ns/100ps

module feat_seq (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        blur_done,
    input  logic                        detect_done,
    input  feat_pkg::row_wr_t           host_img_wr,
    input  logic [feat_pkg::row_aw-1:0] host_blur_addr,
    input  logic [feat_pkg::row_aw-1:0] blur_img_addr,
    input  feat_pkg::row_wr_t           blur_wr,
    input  logic [feat_pkg::row_aw-1:0] detect_addr,
    output feat_pkg::row_wr_t           img_port,
    output logic [feat_pkg::row_aw-1:0] img_rd_addr,
    output feat_pkg::row_wr_t           blur_port,
    output logic [feat_pkg::row_aw-1:0] blur_rd_addr,
    output logic                        blur_start,
    output logic                        detect_start,
    output logic                        busy,
    output logic                        done
);

    feat_pkg::seq_state_t state;
    feat_pkg::seq_state_t state_nxt;

    assign blur_start   = state == feat_pkg::idle && start;
    assign detect_start = state == feat_pkg::blur && blur_done;
    assign busy         = state != feat_pkg::idle;

    always_comb begin
        state_nxt = state;
        case (state)
            feat_pkg::idle: begin
                if (start) begin
                    state_nxt = feat_pkg::blur;
                end
            end
            feat_pkg::blur: begin
                if (blur_done) begin
                    state_nxt = feat_pkg::detect;
                end
            end
            feat_pkg::detect: begin
                if (detect_done) begin
                    state_nxt = feat_pkg::idle;
                end
            end
            default: state_nxt = feat_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= feat_pkg::idle;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= state == feat_pkg::detect && detect_done;   // lands with busy low
        end
    end

    // port owners per state, writes held off elsewhere
    always_comb begin
        img_port     = '0;
        img_rd_addr  = '0;
        blur_port    = '0;
        blur_rd_addr = '0;
        case (state)
            feat_pkg::idle: begin
                img_port     = host_img_wr;
                blur_rd_addr = host_blur_addr;
            end
            feat_pkg::blur: begin
                img_rd_addr = blur_img_addr;
                blur_port   = blur_wr;
            end
            feat_pkg::detect: begin
                img_rd_addr  = detect_addr;
                blur_rd_addr = detect_addr;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/gauss_blur.sv
`timescale 1ns/100ps

module gauss_blur (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    output logic [feat_pkg::row_aw-1:0] img_addr,
    input  feat_pkg::row_t              img_dout,
    input  feat_pkg::row_t              upper,
    input  feat_pkg::row_t              center,
    input  feat_pkg::row_t              lower,
    output logic                        shift,
    output logic                        fill_zero,
    output feat_pkg::row_wr_t           blur_wr,
    output logic                        done
);

    logic                        run;
    logic                        phase;     // 0 read, 1 shift
    logic [feat_pkg::row_aw:0]   cnt;       // row being read, up to n_rows+1
    logic                        last;
    logic                        wr_en;
    logic [feat_pkg::row_aw:0]   wr_row;
    feat_pkg::row_t              top;
    feat_pkg::row_t              mid;
    feat_pkg::row_t              bot;
    feat_pkg::row_t              blurred;
    logic [feat_pkg::pix_w+1:0]  vsum [feat_pkg::n_cols+2];

    assign last      = run && !phase && cnt == (feat_pkg::row_aw+1)'(feat_pkg::n_rows + 1);
    assign img_addr  = cnt[feat_pkg::row_aw-1:0];
    assign shift     = run && phase;
    assign fill_zero = cnt == (feat_pkg::row_aw+1)'(feat_pkg::n_rows);
    assign done      = last;

    // rows 0..14 are blurred while the row below arrives from memory
    // the last row waits for the zero fill to reach the window
    assign top = last ? upper : center;
    assign mid = last ? center : lower;
    assign bot = last ? lower : img_dout;

    assign wr_en  = last || (shift && cnt != '0 && cnt < (feat_pkg::row_aw+1)'(feat_pkg::n_rows));
    assign wr_row = last ? cnt - 2'd2 : cnt - 2'd1;

    always_comb begin
        logic [feat_pkg::pix_w+3:0] hsum;
        vsum[0]                  = '0;   // left pad
        vsum[feat_pkg::n_cols+1] = '0;
        for (int j = 0; j < feat_pkg::n_cols; j++) begin
            vsum[j+1] = {2'b00, top[j*feat_pkg::pix_w +: feat_pkg::pix_w]}
                      + {1'b0, mid[j*feat_pkg::pix_w +: feat_pkg::pix_w], 1'b0}
                      + {2'b00, bot[j*feat_pkg::pix_w +: feat_pkg::pix_w]};
        end
        for (int j = 0; j < feat_pkg::n_cols; j++) begin
            hsum = {2'b00, vsum[j]} + {1'b0, vsum[j+1], 1'b0} + {2'b00, vsum[j+2]}
                 + (feat_pkg::pix_w+4)'(8);
            blurred[j*feat_pkg::pix_w +: feat_pkg::pix_w] = hsum[feat_pkg::pix_w+3:4];
        end
    end

    always_comb begin
        blur_wr.we   = wr_en;
        blur_wr.addr = wr_row[feat_pkg::row_aw-1:0];
        blur_wr.data = blurred;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run   <= 1'b0;
            phase <= 1'b0;
            cnt   <= '0;
        end else if (start) begin
            run   <= 1'b1;
            phase <= 1'b0;
            cnt   <= '0;
        end else if (run) begin
            if (last) begin
                run <= 1'b0;
            end else if (phase) begin
                phase <= 1'b0;
                cnt   <= cnt + 1'b1;
            end else begin
                phase <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/kpt_detect.sv
`timescale 1ns/100ps

module kpt_detect (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  feat_pkg::pixel_t            threshold,
    output logic [feat_pkg::row_aw-1:0] rd_addr,
    input  feat_pkg::row_t              img_dout,
    input  feat_pkg::row_t              blur_dout,
    input  logic [feat_pkg::kpt_aw-1:0] kpt_rd_addr,
    output feat_pkg::kpt_t              kpt_dout,
    output logic [feat_pkg::kpt_cw-1:0] kpt_count,
    output logic                        done
);

    logic                        reading;
    logic                        capturing;
    logic                        scanning;
    logic [feat_pkg::row_aw-1:0] row_idx;
    logic [feat_pkg::row_aw-1:0] col_idx;
    logic [feat_pkg::kpt_cw-1:0] count;
    logic                        last_col;
    logic                        hit;
    feat_pkg::pixel_t            thr;
    feat_pkg::pixel_t            pix;
    feat_pkg::pixel_t            bpix;
    feat_pkg::pixel_t            diff;
    feat_pkg::row_t              img_q;
    feat_pkg::row_t              blur_q;
    feat_pkg::kpt_t              kpt_mem [2**feat_pkg::kpt_aw];

    assign rd_addr   = row_idx;   // same row from both memories
    assign kpt_count = count;

    assign pix      = img_q[col_idx*feat_pkg::pix_w +: feat_pkg::pix_w];
    assign bpix     = blur_q[col_idx*feat_pkg::pix_w +: feat_pkg::pix_w];
    assign diff     = (pix > bpix) ? pix - bpix : bpix - pix;
    assign hit      = scanning && diff > thr;
    assign last_col = col_idx == feat_pkg::row_aw'(feat_pkg::n_cols - 1);
    assign done     = scanning && last_col && row_idx == feat_pkg::row_aw'(feat_pkg::n_rows - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reading   <= 1'b0;
            capturing <= 1'b0;
            scanning  <= 1'b0;
            row_idx   <= '0;
            col_idx   <= '0;
            count     <= '0;
        end else if (start) begin
            reading <= 1'b1;
            row_idx <= '0;
            count   <= '0;
        end else begin
            if (reading) begin
                reading   <= 1'b0;
                capturing <= 1'b1;
            end
            if (capturing) begin
                capturing <= 1'b0;
                scanning  <= 1'b1;
                col_idx   <= '0;
            end
            if (scanning) begin
                col_idx <= col_idx + 1'b1;
                if (last_col) begin
                    scanning <= 1'b0;
                    if (!done) begin
                        row_idx <= row_idx + 1'b1;
                        reading <= 1'b1;   // next row
                    end
                end
            end
            if (hit) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            thr <= threshold;
        end
        if (capturing) begin
            img_q  <= img_dout;
            blur_q <= blur_dout;
        end
        if (hit) begin
            kpt_mem[count[feat_pkg::kpt_aw-1:0]] <= '{row: row_idx, col: col_idx};
        end
        kpt_dout <= kpt_mem[kpt_rd_addr];   // host read port
    end

endmodule

// File: hdl/line_buffer.sv
`timescale 1ns/100ps

module line_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           shift,
    input  logic           fill_zero,
    input  feat_pkg::row_t din,
    output feat_pkg::row_t upper,
    output feat_pkg::row_t center,
    output feat_pkg::row_t lower
);

    // cleared window doubles as the zero row above image row 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upper  <= '0;
            center <= '0;
            lower  <= '0;
        end else if (shift) begin
            upper  <= center;
            center <= lower;
            if (fill_zero) begin
                lower <= '0;   // row below the image
            end else begin
                lower <= din;
            end
        end
    end

endmodule

// File: hdl/row_mem.sv
`timescale 1ns/100ps

module row_mem (
    input  logic                        clk,
    input  feat_pkg::row_wr_t           wr,
    input  logic [feat_pkg::row_aw-1:0] rd_addr,
    output feat_pkg::row_t              dout
);

    feat_pkg::row_t mem [feat_pkg::n_rows];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
        dout <= mem[rd_addr];   // one cycle read
    end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the feat_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_feat_core -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_feat_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// File: sim.f
hdl/feat_pkg.sv
hdl/row_mem.sv
hdl/line_buffer.sv
hdl/gauss_blur.sv
hdl/kpt_detect.sv
hdl/feat_seq.sv
hdl/feat_core.sv
tb/feat_core_asserts.sv
tb/tb_feat_core.sv

// File: tb/feat_core_asserts.sv
`timescale 1ns/100ps

module feat_core_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        start,
    input logic                        busy,
    input logic                        done,
    input logic [feat_pkg::kpt_cw-1:0] kpt_count
);

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done held for more than one cycle");

    // done lands in the cycle busy falls
    done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else $error("busy still high with done");

    busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(start))
        else $error("busy rose without a start");

    count_max: assert property (@(posedge clk) disable iff (!rst_n)
        kpt_count <= 9'd256)
        else $error("kpt_count above 256");

endmodule

bind feat_core feat_core_asserts feat_core_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .kpt_count (kpt_count)
);

// File: tb/tb_feat_core.sv
`timescale 1ns/100ps

module tb_feat_core;

    logic                        clk;
    logic                        rst_n;
    logic                        start;
    feat_pkg::pixel_t            threshold;
    feat_pkg::row_wr_t           img_wr;
    logic [feat_pkg::row_aw-1:0] blur_rd_addr;
    feat_pkg::row_t              blur_dout;
    logic [feat_pkg::kpt_aw-1:0] kpt_rd_addr;
    feat_pkg::kpt_t              kpt_dout;
    logic [feat_pkg::kpt_cw-1:0] kpt_count;
    logic                        busy;
    logic                        done;

    integer                      seed;
    feat_pkg::row_t              image [feat_pkg::n_rows];   // what the image memory should hold
    feat_pkg::pixel_t            run_thr;
    feat_pkg::row_t              got_blur [feat_pkg::n_rows];
    feat_pkg::kpt_t              got_kpts [2**feat_pkg::kpt_aw];
    logic [feat_pkg::kpt_cw-1:0] got_count;
    feat_pkg::kpt_t              exp_kpts [$];
    int                          runs_read = 0;
    int                          runs_checked = 0;
    int                          ref_latency = 0;

    feat_core feat_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .threshold    (threshold),
        .img_wr       (img_wr),
        .blur_rd_addr (blur_rd_addr),
        .blur_dout    (blur_dout),
        .kpt_rd_addr  (kpt_rd_addr),
        .kpt_dout     (kpt_dout),
        .kpt_count    (kpt_count),
        .busy         (busy),
        .done         (done)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got == exp) else
            stop_on_error($sformatf("[FAIL] %s: got %0h expected %0h", name, got, exp));
    endtask

    function automatic int img_pixel(input int r, input int c);
        if (r < 0 || r >= feat_pkg::n_rows || c < 0 || c >= feat_pkg::n_cols) begin
            return 0;   // zero padding
        end
        return int'(image[r][c*feat_pkg::pix_w +: feat_pkg::pix_w]);
    endfunction

    function automatic feat_pkg::row_t blur_row(input int r);
        feat_pkg::row_t row;
        int             sum;
        row = '0;
        for (int c = 0; c < feat_pkg::n_cols; c++) begin
            sum = 8;   // rounding
            for (int dr = -1; dr <= 1; dr++) begin
                for (int dc = -1; dc <= 1; dc++) begin
                    sum += img_pixel(r + dr, c + dc) * (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
                end
            end
            row[c*feat_pkg::pix_w +: feat_pkg::pix_w] = feat_pkg::pix_w'(sum >> 4);
        end
        return row;
    endfunction

    function automatic void find_keypoints(input feat_pkg::pixel_t thr);
        feat_pkg::row_t blurred;
        feat_pkg::kpt_t kpt;
        int             diff;
        exp_kpts.delete();
        for (int r = 0; r < feat_pkg::n_rows; r++) begin
            blurred = blur_row(r);
            for (int c = 0; c < feat_pkg::n_cols; c++) begin
                diff = img_pixel(r, c) - int'(blurred[c*feat_pkg::pix_w +: feat_pkg::pix_w]);
                if (diff < 0) begin
                    diff = -diff;
                end
                if (diff > int'(thr)) begin
                    kpt.row = feat_pkg::row_aw'(r);
                    kpt.col = feat_pkg::row_aw'(c);
                    exp_kpts.push_back(kpt);   // row-major order
                end
            end
        end
    endfunction

    task automatic check_results();
        for (int r = 0; r < feat_pkg::n_rows; r++) begin
            check_value($sformatf("blur_dout[%0d]", r), got_blur[r], blur_row(r));
        end
        find_keypoints(run_thr);
        check_value("kpt_count", 128'(got_count), 128'(exp_kpts.size()));
        for (int i = 0; i < exp_kpts.size(); i++) begin
            check_value($sformatf("kpt_dout[%0d]", i), 128'(got_kpts[i]), 128'(exp_kpts[i]));
        end
    endtask

    // compare process picks up each finished readback
    always @(posedge clk) begin
        if (runs_checked != runs_read) begin
            check_results();
            runs_checked <= runs_checked + 1;
        end
    end

    task automatic load_image();
        for (int r = 0; r < feat_pkg::n_rows; r++) begin
            for (int w = 0; w < feat_pkg::n_cols * feat_pkg::pix_w / 32; w++) begin
                image[r][w*32 +: 32] = $random(seed);
            end
            @(posedge clk);
            img_wr <= '{we: 1'b1, addr: feat_pkg::row_aw'(r), data: image[r]};
        end
        @(posedge clk);
        img_wr.we <= 1'b0;
    endtask

    task automatic run_core(input feat_pkg::pixel_t thr, input bit extra_start,
                            input bit stray_write);
        int cycles;
        bit finished;
        cycles   = 0;
        finished = 1'b0;
        run_thr  = thr;
        @(posedge clk);
        threshold <= thr;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!finished) begin
            @(posedge clk);
            cycles++;
            start <= extra_start && (cycles == 10 || cycles == 100);   // both phases
            if (stray_write && cycles == 20) begin
                img_wr <= '{we: 1'b1, addr: 4'd5, data: ~image[5]};
            end else begin
                img_wr.we <= 1'b0;
            end
            if (done) begin
                finished = 1'b1;
            end
            check_value("busy", 128'(busy), 128'(!finished));
            assert (cycles < 2000) else stop_on_error("timeout while waiting for done");
        end
        // run length depends only on the image size
        if (ref_latency == 0) begin
            ref_latency = cycles;
        end else begin
            check_value("done latency", 128'(cycles), 128'(ref_latency));
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            check_value("done", 128'(done), 128'(0));   // one done per accepted start
            check_value("busy", 128'(busy), 128'(0));
        end
    endtask

    task automatic read_back();
        for (int r = 0; r < feat_pkg::n_rows; r++) begin
            @(posedge clk);
            blur_rd_addr <= feat_pkg::row_aw'(r);
            @(posedge clk);
            @(posedge clk);
            got_blur[r] = blur_dout;
        end
        got_count = kpt_count;
        for (int i = 0; i < int'(got_count); i++) begin
            @(posedge clk);
            kpt_rd_addr <= feat_pkg::kpt_aw'(i);
            @(posedge clk);
            @(posedge clk);
            got_kpts[i] = kpt_dout;
        end
        runs_read <= runs_read + 1;
        @(posedge clk);
    endtask

    task automatic wait_checked();
        int cycles;
        cycles = 0;
        while (runs_checked != runs_read) begin
            @(posedge clk);
            cycles++;
            assert (cycles < 50) else stop_on_error("compare process never finished a run");
        end
    endtask

    initial begin
        seed         = 32'h0ed9_c30b;
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        threshold    = '0;
        img_wr       = '0;
        blur_rd_addr = '0;
        kpt_rd_addr  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("busy", 128'(busy), 128'(0));
        check_value("done", 128'(done), 128'(0));
        check_value("kpt_count", 128'(kpt_count), 128'(0));

        load_image();
        run_core(8'd40, 1'b1, 1'b0);   // stray starts while busy
        read_back();
        wait_checked();

        run_core(8'd40, 1'b0, 1'b1);   // same image with a write during the run
        read_back();
        wait_checked();

        run_core(8'd255, 1'b0, 1'b0);
        read_back();
        wait_checked();
        check_value("kpt_count", 128'(got_count), 128'(0));

        load_image();
        run_core(8'd0, 1'b0, 1'b0);
        read_back();
        wait_checked();

        load_image();
        run_core(8'd24, 1'b1, 1'b1);
        read_back();
        wait_checked();

        if (runs_checked == 5) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_on_error("compare process checked the wrong number of runs");
        end
    end

endmodule
